// File: design/alu_handshake_fsm.sv
`timescale 1ns/10ps

module alu_handshake_fsm (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      aluop_pending,
  input  logic                      op1_valid,
  input  logic                      op2_valid,
  input  de_pipe_pkg::fu_csr_out_t  csr_out,
  input  logic                      op3_store_issued,
  output de_pipe_pkg::fu_csr_in_t   csr_in,
  output logic                      op_done
);

  de_pipe_pkg::alu_state_e state;

  assign op_done = (state == de_pipe_pkg::READ_RESULT);

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= de_pipe_pkg::IDLE;
      csr_in <= '0;
    end else begin
      case (state)
        de_pipe_pkg::IDLE: begin
          csr_in <= '0;
          if (aluop_pending && op1_valid) state <= de_pipe_pkg::WAIT_OP1_READY;
        end
        de_pipe_pkg::WAIT_OP1_READY: begin
          if (csr_out.op1_ready) begin
            state             <= de_pipe_pkg::LOAD_OP1;
            csr_in.op1_stable <= 1'b1;
          end
        end
        de_pipe_pkg::LOAD_OP1: begin
          csr_in.op1_stable <= 1'b0;                  // Single-cycle strobe
          if (op2_valid) state <= de_pipe_pkg::WAIT_OP2_READY;
        end
        de_pipe_pkg::WAIT_OP2_READY: begin
          if (csr_out.op2_ready) begin
            state             <= de_pipe_pkg::LOAD_OP2;
            csr_in.op2_stable <= 1'b1;
          end
        end
        de_pipe_pkg::LOAD_OP2: begin
          csr_in.op2_stable <= 1'b0;
          state             <= de_pipe_pkg::WAIT_RESULT;
        end
        de_pipe_pkg::WAIT_RESULT: begin
          if (csr_out.result_valid) begin
            state               <= de_pipe_pkg::READ_RESULT;
            csr_in.result_taken <= 1'b1;               // Held until OP3 is stored
          end
        end
        de_pipe_pkg::READ_RESULT: begin
          if (op3_store_issued) begin
            state               <= de_pipe_pkg::IDLE;
            csr_in.result_taken <= 1'b0;
          end
        end
        default: begin
          state  <= de_pipe_pkg::IDLE;
          csr_in <= '0;
        end
      endcase
    end
  end

  a_stable_excl: assert property (@(posedge clk) disable iff (reset)
    !(csr_in.op1_stable && csr_in.op2_stable));

endmodule

// File: design/alu_operand_regs.sv
`timescale 1ns/10ps

module alu_operand_regs (
  input  logic                                clk,
  input  logic                                reset,
  input  de_pipe_pkg::wb_to_de_t              wb,
  input  logic                                op_done,
  output logic [de_pipe_pkg::ALUOP_W-1:0]     aluop,
  output logic [rv_isa_pkg::XLEN-1:0]         op1,
  output logic [rv_isa_pkg::XLEN-1:0]         op2,
  output logic                                aluop_pending,
  output logic                                op1_valid,
  output logic                                op2_valid
);

  // Operand payload, loaded by writebacks to the mapped indexes
  always_ff @(posedge clk) begin
    if (wb.wr_reg) begin
      case (wb.wregno)
        de_pipe_pkg::ALUOP_IDX: aluop <= wb.regval[de_pipe_pkg::ALUOP_W-1:0];
        de_pipe_pkg::OP1_IDX:   op1   <= wb.regval;
        de_pipe_pkg::OP2_IDX:   op2   <= wb.regval;
        default: ;
      endcase
    end
  end

  ////////////////////
  // Valid flags
  always_ff @(posedge clk) begin
    if (reset) begin
      aluop_pending <= 1'b0;
      op1_valid     <= 1'b0;
      op2_valid     <= 1'b0;
    end else begin
      if (op_done) begin
        aluop_pending <= 1'b0;
        op1_valid     <= 1'b0;
        op2_valid     <= 1'b0;
      end
      // A fresh load for the next operation survives a same-cycle clear
      if (wb.wr_reg && (wb.wregno == de_pipe_pkg::ALUOP_IDX)) aluop_pending <= 1'b1;
      if (wb.wr_reg && (wb.wregno == de_pipe_pkg::OP1_IDX))   op1_valid     <= 1'b1;
      if (wb.wr_reg && (wb.wregno == de_pipe_pkg::OP2_IDX))   op2_valid     <= 1'b1;
    end
  end

endmodule

// File: design/de_issue_latch.sv
`timescale 1ns/10ps

module de_issue_latch (
  input  logic                         clk,
  input  logic                         reset,
  input  de_pipe_pkg::fe_to_de_t       fe,
  input  de_pipe_pkg::decode_t         dec,
  input  logic [rv_isa_pkg::XLEN-1:0]  rs1_val,
  input  logic [rv_isa_pkg::XLEN-1:0]  rs2_val,
  input  de_pipe_pkg::fu_to_de_t       fu_in,
  input  logic                         stall,
  output logic                         op3_store_issued,
  output de_pipe_pkg::de_latch_t       de_out
);

  logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_idx;
  logic [rv_isa_pkg::XLEN-1:0]      rs2_sel;
  de_pipe_pkg::de_latch_t           nxt;

  assign rs2_idx = fe.inst.r.rs2;

  // FU result and status are read through rs2 of a store
  always_comb begin
    if (rs2_idx == de_pipe_pkg::OP3_IDX) begin
      rs2_sel = fu_in.op3;
    end else if (rs2_idx == de_pipe_pkg::CSR_OUT_IDX) begin
      rs2_sel = {{(rv_isa_pkg::XLEN - de_pipe_pkg::CSR_OUT_W){1'b0}}, fu_in.csr_out};
    end else begin
      rs2_sel = rs2_val;
    end
  end

  assign op3_store_issued = fe.valid && !stall && (dec.op_i == rv_isa_pkg::IOP_SW) &&
                            (rs2_idx == de_pipe_pkg::OP3_IDX);

  ////////////////////
  // Pipeline latch
  assign nxt = '{valid: fe.valid, inst: fe.inst, pc: fe.pc, op_i: dec.op_i,
                 rs1_val: rs1_val, rs2_val: rs2_sel, imm: dec.imm,
                 is_br: dec.is_br, is_jmp: dec.is_jmp, rd_mem: dec.rd_mem,
                 wr_mem: dec.wr_mem, wr_reg: dec.wr_reg, rd: fe.inst.r.rd};

  always_ff @(posedge clk) begin
    if (reset || stall) begin
      de_out <= '0;                   // Stall leaves a bubble behind
    end else begin
      de_out <= nxt;
    end
  end

endmodule

// File: design/de_pipe_pkg.sv
package de_pipe_pkg;

  // From fetch
  typedef struct packed {
    logic                              valid;
    rv_isa_pkg::instr_u                inst;
    logic [rv_isa_pkg::XLEN-1:0]       pc;
  } fe_to_de_t;

  // From writeback
  typedef struct packed {
    logic                              wr_reg;
    logic [rv_isa_pkg::REG_IDX_W-1:0]  wregno;
    logic [rv_isa_pkg::XLEN-1:0]       regval;
  } wb_to_de_t;

  // Decoder result, before operands are attached
  typedef struct packed {
    rv_isa_pkg::iop_e                  op_i;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    rv_isa_pkg::fmt_kind_e             fmt;
    logic                              is_br;
    logic                              is_jmp;
    logic                              rd_mem;
    logic                              wr_mem;
    logic                              wr_reg;
    logic                              use_rs1;
    logic                              use_rs2;
  } decode_t;

  // DE latch handed to AGEX
  typedef struct packed {
    logic                              valid;
    logic [rv_isa_pkg::XLEN-1:0]       inst;
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    rv_isa_pkg::iop_e                  op_i;
    logic [rv_isa_pkg::XLEN-1:0]       rs1_val;
    logic [rv_isa_pkg::XLEN-1:0]       rs2_val;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    logic                              is_br;
    logic                              is_jmp;
    logic                              rd_mem;
    logic                              wr_mem;
    logic                              wr_reg;
    logic [rv_isa_pkg::REG_IDX_W-1:0]  rd;
  } de_latch_t;

  ////////////////////
  // External ALU register map

  localparam int ALUOP_W   = 4;
  localparam int CSR_IN_W  = 3;
  localparam int CSR_OUT_W = 3;

  localparam logic [rv_isa_pkg::REG_IDX_W-1:0] ALUOP_IDX   = 5'd28;
  localparam logic [rv_isa_pkg::REG_IDX_W-1:0] OP1_IDX     = 5'd29;
  localparam logic [rv_isa_pkg::REG_IDX_W-1:0] OP2_IDX     = 5'd30;
  localparam logic [rv_isa_pkg::REG_IDX_W-1:0] OP3_IDX     = 5'd31;
  localparam logic [rv_isa_pkg::REG_IDX_W-1:0] CSR_OUT_IDX = 5'd27;

  // Bit 0 result_taken, bit 1 op1_stable, bit 2 op2_stable
  typedef struct packed {
    logic op2_stable;
    logic op1_stable;
    logic result_taken;
  } fu_csr_in_t;

  // Bit 0 op1_ready, bit 1 op2_ready, bit 2 result_valid
  typedef struct packed {
    logic result_valid;
    logic op2_ready;
    logic op1_ready;
  } fu_csr_out_t;

  typedef struct packed {
    fu_csr_in_t                        csr_in;
    logic [ALUOP_W-1:0]                aluop;
    logic [rv_isa_pkg::XLEN-1:0]       op2;
    logic [rv_isa_pkg::XLEN-1:0]       op1;
  } de_to_fu_t;

  typedef struct packed {
    fu_csr_out_t                       csr_out;
    logic [rv_isa_pkg::XLEN-1:0]       op3;
  } fu_to_de_t;

  typedef enum logic [2:0] {
    IDLE, WAIT_OP1_READY, LOAD_OP1, WAIT_OP2_READY, LOAD_OP2, WAIT_RESULT, READ_RESULT
  } alu_state_e;

endpackage

// File: design/de_stage_top.sv
`timescale 1ns/10ps

module de_stage_top (
  input  logic                    clk,
  input  logic                    reset,
  input  de_pipe_pkg::fe_to_de_t  fe,
  input  de_pipe_pkg::wb_to_de_t  wb,
  input  logic                    br_mispred,
  input  de_pipe_pkg::fu_to_de_t  fu_in,
  output logic                    stall,
  output de_pipe_pkg::de_latch_t  de_out,
  output de_pipe_pkg::de_to_fu_t  fu_out
);

  de_pipe_pkg::decode_t                 dec;
  logic [rv_isa_pkg::XLEN-1:0]          rs1_val;
  logic [rv_isa_pkg::XLEN-1:0]          rs2_val;
  logic [de_pipe_pkg::ALUOP_W-1:0]      aluop;
  logic [rv_isa_pkg::XLEN-1:0]          op1;
  logic [rv_isa_pkg::XLEN-1:0]          op2;
  logic                                 aluop_pending;
  logic                                 op1_valid;
  logic                                 op2_valid;
  logic                                 op_done;
  logic                                 op3_store_issued;
  de_pipe_pkg::fu_csr_in_t              csr_in;

  ////////////////////
  // Decode, operands, hazards
  inst_decoder u_dec (
    .instr (fe.inst),
    .dec   (dec)
  );

  reg_file u_rf (
    .clk     (clk),
    .reset   (reset),
    .wb      (wb),
    .rs1_idx (fe.inst.r.rs1),
    .rs2_idx (fe.inst.r.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  scoreboard u_sb (
    .clk        (clk),
    .reset      (reset),
    .dec        (dec),
    .valid      (fe.valid),
    .rs1_idx    (fe.inst.r.rs1),
    .rs2_idx    (fe.inst.r.rs2),
    .rd_idx     (fe.inst.r.rd),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall)
  );

  de_issue_latch u_latch (
    .clk              (clk),
    .reset            (reset),
    .fe               (fe),
    .dec              (dec),
    .rs1_val          (rs1_val),
    .rs2_val          (rs2_val),
    .fu_in            (fu_in),
    .stall            (stall),
    .op3_store_issued (op3_store_issued),
    .de_out           (de_out)
  );

  ////////////////////
  // External ALU link
  alu_operand_regs u_ops (
    .clk           (clk),
    .reset         (reset),
    .wb            (wb),
    .op_done       (op_done),
    .aluop         (aluop),
    .op1           (op1),
    .op2           (op2),
    .aluop_pending (aluop_pending),
    .op1_valid     (op1_valid),
    .op2_valid     (op2_valid)
  );

  alu_handshake_fsm u_fsm (
    .clk              (clk),
    .reset            (reset),
    .aluop_pending    (aluop_pending),
    .op1_valid        (op1_valid),
    .op2_valid        (op2_valid),
    .csr_out          (fu_in.csr_out),
    .op3_store_issued (op3_store_issued),
    .csr_in           (csr_in),
    .op_done          (op_done)
  );

  assign fu_out = '{csr_in: csr_in, aluop: aluop, op2: op2, op1: op1};

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
  input  rv_isa_pkg::instr_u   instr,
  output de_pipe_pkg::decode_t dec
);

  logic [rv_isa_pkg::XLEN-1:0] word;      // Raw view for I/U/J immediates
  logic [9:0]                  f7_f3;
  rv_isa_pkg::iop_e            op;
  rv_isa_pkg::fmt_kind_e       fmt;
  rv_isa_pkg::imm_kind_e       kind;
  logic [rv_isa_pkg::XLEN-1:0] imm;

  assign word  = instr;
  assign f7_f3 = {instr.r.funct7, instr.r.funct3};

  ////////////////////
  // Operation match, anything unknown stays INVALID
  always_comb begin
    op = rv_isa_pkg::IOP_INVALID;
    case (instr.r.opcode)
      rv_isa_pkg::OPC_OP: begin
        case (f7_f3)
          10'b0000000_000: op = rv_isa_pkg::IOP_ADD;
          10'b0100000_000: op = rv_isa_pkg::IOP_SUB;
          10'b0000000_111: op = rv_isa_pkg::IOP_AND;
          10'b0000000_110: op = rv_isa_pkg::IOP_OR;
          10'b0000000_100: op = rv_isa_pkg::IOP_XOR;
          10'b0000000_010: op = rv_isa_pkg::IOP_SLT;
          10'b0000000_011: op = rv_isa_pkg::IOP_SLTU;
          10'b0100000_101: op = rv_isa_pkg::IOP_SRA;
          10'b0000000_101: op = rv_isa_pkg::IOP_SRL;
          10'b0000000_001: op = rv_isa_pkg::IOP_SLL;
          default: ;                                   // MUL lands here
        endcase
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        case (instr.r.funct3)
          3'b000: op = rv_isa_pkg::IOP_ADDI;
          3'b111: op = rv_isa_pkg::IOP_ANDI;
          3'b110: op = rv_isa_pkg::IOP_ORI;
          3'b100: op = rv_isa_pkg::IOP_XORI;
          3'b010: op = rv_isa_pkg::IOP_SLTI;
          3'b011: op = rv_isa_pkg::IOP_SLTIU;
          default: begin
            if (f7_f3 == 10'b0000000_001) op = rv_isa_pkg::IOP_SLLI;
            if (f7_f3 == 10'b0000000_101) op = rv_isa_pkg::IOP_SRLI;
            if (f7_f3 == 10'b0100000_101) op = rv_isa_pkg::IOP_SRAI;
          end
        endcase
      end
      rv_isa_pkg::OPC_LUI:   op = rv_isa_pkg::IOP_LUI;
      rv_isa_pkg::OPC_AUIPC: op = rv_isa_pkg::IOP_AUIPC;
      rv_isa_pkg::OPC_JAL:   op = rv_isa_pkg::IOP_JAL;
      rv_isa_pkg::OPC_LOAD:  if (instr.r.funct3 == 3'b010) op = rv_isa_pkg::IOP_LW;
      rv_isa_pkg::OPC_STORE: if (instr.r.funct3 == 3'b010) op = rv_isa_pkg::IOP_SW;
      rv_isa_pkg::OPC_JALR:  if (instr.r.funct3 == 3'b000) op = rv_isa_pkg::IOP_JALR;
      rv_isa_pkg::OPC_BRANCH: begin
        case (instr.r.funct3)
          3'b000: op = rv_isa_pkg::IOP_BEQ;
          3'b001: op = rv_isa_pkg::IOP_BNE;
          3'b100: op = rv_isa_pkg::IOP_BLT;
          3'b101: op = rv_isa_pkg::IOP_BGE;
          3'b110: op = rv_isa_pkg::IOP_BLTU;
          3'b111: op = rv_isa_pkg::IOP_BGEU;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  // Format and immediate kind follow from the operation
  always_comb begin
    fmt  = rv_isa_pkg::FMT_U;      // No sources read, also used for INVALID
    kind = rv_isa_pkg::IMM_NONE;
    case (op)
      rv_isa_pkg::IOP_ADD, rv_isa_pkg::IOP_SUB, rv_isa_pkg::IOP_AND, rv_isa_pkg::IOP_OR,
      rv_isa_pkg::IOP_XOR, rv_isa_pkg::IOP_SLT, rv_isa_pkg::IOP_SLTU, rv_isa_pkg::IOP_SRA,
      rv_isa_pkg::IOP_SRL, rv_isa_pkg::IOP_SLL:
        fmt = rv_isa_pkg::FMT_R;
      rv_isa_pkg::IOP_ADDI, rv_isa_pkg::IOP_ANDI, rv_isa_pkg::IOP_ORI, rv_isa_pkg::IOP_XORI,
      rv_isa_pkg::IOP_SLTI, rv_isa_pkg::IOP_SLTIU, rv_isa_pkg::IOP_SRAI, rv_isa_pkg::IOP_SRLI,
      rv_isa_pkg::IOP_SLLI, rv_isa_pkg::IOP_LW, rv_isa_pkg::IOP_JALR: begin
        fmt  = rv_isa_pkg::FMT_I;
        kind = rv_isa_pkg::IMM_I;
      end
      rv_isa_pkg::IOP_SW: begin
        fmt  = rv_isa_pkg::FMT_S;
        kind = rv_isa_pkg::IMM_S;
      end
      rv_isa_pkg::IOP_BEQ, rv_isa_pkg::IOP_BNE, rv_isa_pkg::IOP_BLT, rv_isa_pkg::IOP_BGE,
      rv_isa_pkg::IOP_BLTU, rv_isa_pkg::IOP_BGEU: begin
        fmt  = rv_isa_pkg::FMT_S;  // Branches read both sources like a store
        kind = rv_isa_pkg::IMM_B;
      end
      rv_isa_pkg::IOP_LUI, rv_isa_pkg::IOP_AUIPC: kind = rv_isa_pkg::IMM_U;
      rv_isa_pkg::IOP_JAL:                        kind = rv_isa_pkg::IMM_J;
      default: ;
    endcase
  end

  // Sign-extended immediate
  always_comb begin
    case (kind)
      rv_isa_pkg::IMM_I: imm = {{20{word[31]}}, word[31:20]};
      rv_isa_pkg::IMM_S: imm = {{20{instr.sb.imm_hi[6]}}, instr.sb.imm_hi, instr.sb.imm_lo};
      rv_isa_pkg::IMM_B: imm = {{19{instr.sb.imm_hi[6]}}, instr.sb.imm_hi[6], instr.sb.imm_lo[0],
                                instr.sb.imm_hi[5:0], instr.sb.imm_lo[4:1], 1'b0};
      rv_isa_pkg::IMM_U: imm = {word[31:12], 12'b0};
      rv_isa_pkg::IMM_J: imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
      default:           imm = '0;
    endcase
  end

  always_comb begin
    dec.op_i    = op;
    dec.imm     = imm;
    dec.fmt     = fmt;
    dec.is_br   = (kind == rv_isa_pkg::IMM_B);
    dec.is_jmp  = (op == rv_isa_pkg::IOP_JAL) || (op == rv_isa_pkg::IOP_JALR);
    dec.rd_mem  = (op == rv_isa_pkg::IOP_LW);
    dec.wr_mem  = (op == rv_isa_pkg::IOP_SW);
    dec.wr_reg  = ((fmt == rv_isa_pkg::FMT_R) || (kind == rv_isa_pkg::IMM_I) ||
                   (kind == rv_isa_pkg::IMM_U) || (kind == rv_isa_pkg::IMM_J)) &&
                  (instr.r.rd != '0);                  // x0 writes are dropped here
    dec.use_rs1 = (fmt != rv_isa_pkg::FMT_U);
    dec.use_rs2 = (fmt == rv_isa_pkg::FMT_R) || (fmt == rv_isa_pkg::FMT_S);
    a_invalid_no_wr: assert (!(dec.op_i == rv_isa_pkg::IOP_INVALID && dec.wr_reg));
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                             clk,
  input  logic                             reset,
  input  de_pipe_pkg::wb_to_de_t           wb,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_idx,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_idx,
  output logic [rv_isa_pkg::XLEN-1:0]      rs1_val,
  output logic [rv_isa_pkg::XLEN-1:0]      rs2_val
);

  logic [rv_isa_pkg::XLEN-1:0] regs [rv_isa_pkg::NUM_REGS];
  logic                        wr_en;

  // x0 and the ALU operand slots never land in the array
  assign wr_en = wb.wr_reg && (wb.wregno != '0) &&
                 (wb.wregno != de_pipe_pkg::ALUOP_IDX) &&
                 (wb.wregno != de_pipe_pkg::OP1_IDX) &&
                 (wb.wregno != de_pipe_pkg::OP2_IDX);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.wregno] <= wb.regval;
    end
  end

  // Same-cycle writeback bypass
  assign rs1_val = (wr_en && (wb.wregno == rs1_idx)) ? wb.regval : regs[rs1_idx];
  assign rs2_val = (wr_en && (wb.wregno == rs2_idx)) ? wb.regval : regs[rs2_idx];

endmodule

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN      = 32;
  localparam int NUM_REGS  = 32;
  localparam int REG_IDX_W = 5;

  // Major opcodes recognised by decode
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // Internal operation code carried down the pipe
  typedef enum logic [5:0] {
    IOP_ADD, IOP_SUB, IOP_AND, IOP_OR, IOP_XOR, IOP_SLT, IOP_SLTU,
    IOP_SRA, IOP_SRL, IOP_SLL,
    IOP_ADDI, IOP_ANDI, IOP_ORI, IOP_XORI, IOP_SLTI, IOP_SLTIU,
    IOP_SRAI, IOP_SRLI, IOP_SLLI,
    IOP_LUI, IOP_AUIPC, IOP_LW, IOP_SW, IOP_JAL, IOP_JALR,
    IOP_BEQ, IOP_BNE, IOP_BLT, IOP_BGE, IOP_BLTU, IOP_BGEU,
    IOP_INVALID
  } iop_e;

  typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

  typedef enum logic [1:0] {FMT_R, FMT_I, FMT_S, FMT_U} fmt_kind_e;

  ////////////////////
  // Two views of one instruction word

  typedef struct packed {
    logic [6:0]           funct7;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [REG_IDX_W-1:0] rd;
    logic [6:0]           opcode;
  } r_fields_t;

  typedef struct packed {
    logic [6:0]           imm_hi;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rs1;
    logic [2:0]           funct3;
    logic [4:0]           imm_lo;    // Low immediate bits sit where rd would be
    logic [6:0]           opcode;
  } sb_fields_t;

  typedef union packed {
    r_fields_t  r;
    sb_fields_t sb;
  } instr_u;

endpackage

// File: design/scoreboard.sv
`timescale 1ns/10ps

module scoreboard (
  input  logic                             clk,
  input  logic                             reset,
  input  de_pipe_pkg::decode_t             dec,
  input  logic                             valid,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_idx,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_idx,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rd_idx,
  input  de_pipe_pkg::wb_to_de_t           wb,
  input  logic                             br_mispred,
  output logic                             stall
);

  logic [rv_isa_pkg::NUM_REGS-1:0] in_use;     // One bit per destination in flight
  logic                            hazard;

  assign hazard = valid && ((dec.use_rs1 && in_use[rs1_idx]) ||
                            (dec.use_rs2 && in_use[rs2_idx]));
  assign stall  = hazard || br_mispred;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_use <= '0;
    end else begin
      if (valid && !stall && dec.wr_reg) begin
        in_use[rd_idx] <= 1'b1;
      end
      if (wb.wr_reg) begin
        in_use[wb.wregno] <= 1'b0;   // Last assignment, so retire beats issue
      end
    end
  end

  // Nothing upstream may ever mark x0 busy
  a_x0_free: assert property (@(posedge clk) disable iff (reset) !in_use[0]);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the DE stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_de_stage

./obj_dir/Vtb_de_stage | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

// File: verification/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int de_errors    = 0;
int csr_errors   = 0;
int stall_errors = 0;
int word_errors  = 0;

task automatic check_de_out(input de_pipe_pkg::de_latch_t got,
                            input de_pipe_pkg::de_latch_t exp);
  if (got !== exp) begin
    de_errors++;
    $display("ERROR de_out exp %h got %h at %0t", exp, got, $time);
  end
endtask

task automatic check_csr_in(input de_pipe_pkg::fu_csr_in_t got,
                            input de_pipe_pkg::fu_csr_in_t exp);
  if (got !== exp) begin
    csr_errors++;
    $display("ERROR fu_out.csr_in exp %h got %h at %0t", exp, got, $time);
  end
endtask

task automatic check_stall(input logic got, input logic exp);
  if (got !== exp) begin
    stall_errors++;
    $display("ERROR stall exp %h got %h at %0t", exp, got, $time);
  end
endtask

// Operand words seen by the FU
task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    word_errors++;
    $display("ERROR %s exp %h got %h at %0t", name, exp, got, $time);
  end
endtask

`endif

// File: verification/tb_de_stage.sv
`timescale 1ns/10ps

module tb_de_stage;

  localparam int NUM_ROWS     = 19;
  localparam int MAX_FU_DELAY = 8;
  localparam int WATCHDOG_NS  = (NUM_ROWS + 6 * MAX_FU_DELAY + 10) * 20 * 4;

  typedef struct packed {
    logic [31:0]      instr;
    logic             wb_en;
    logic [4:0]       wb_idx;
    logic             br;
    rv_isa_pkg::iop_e op;
    logic [31:0]      imm;
    logic [4:0]       flags;     // is_br, is_jmp, rd_mem, wr_mem, wr_reg
    logic             stall;
    logic             wait_fu;   // Hold off until the FU result is taken
  } stim_row_t;

  logic                   clk;
  logic                   reset;
  de_pipe_pkg::fe_to_de_t fe;
  de_pipe_pkg::wb_to_de_t wb;
  logic                   br_mispred;
  de_pipe_pkg::fu_to_de_t fu_in;
  logic                   stall;
  de_pipe_pkg::de_latch_t de_out;
  de_pipe_pkg::de_to_fu_t fu_out;

  stim_row_t   rows [NUM_ROWS];
  logic [31:0] model_regs [32];
  logic [3:0]  exp_aluop;
  logic [31:0] exp_op1;
  logic [31:0] exp_op2;
  logic        fu_done;
  logic        op3_sent;

  `include "tb_checks.svh"

  de_stage_top DUT (.clk(clk), .reset(reset), .fe(fe), .wb(wb), .br_mispred(br_mispred),
                    .fu_in(fu_in), .stall(stall), .de_out(de_out), .fu_out(fu_out));

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Only ordinary registers live in the array
  function automatic logic writable(input logic [4:0] idx);
    return (idx != 5'd0) && (idx != 5'd28) && (idx != 5'd29) && (idx != 5'd30);
  endfunction

  task automatic put_row(input int i, input logic [31:0] instr, input logic wb_en,
                         input logic [4:0] wb_idx, input logic br, input rv_isa_pkg::iop_e op,
                         input logic [31:0] imm, input logic [4:0] flags, input logic stl,
                         input logic wait_fu);
    rows[i] = '{instr, wb_en, wb_idx, br, op, imm, flags, stl, wait_fu};
  endtask

  task automatic fill_table();
    put_row(0,  32'h00000013, 1, 5'd1, 0, rv_isa_pkg::IOP_ADDI,  32'h0, 5'b00000, 0, 0);
    put_row(1,  32'h002081B3, 1, 5'd2, 0, rv_isa_pkg::IOP_ADD,   32'h0, 5'b00001, 0, 0);
    put_row(2,  32'h40118233, 1, 5'd3, 0, rv_isa_pkg::IOP_SUB,   32'h0, 5'b00001, 1, 0);
    put_row(3,  32'h40118233, 0, 5'd0, 0, rv_isa_pkg::IOP_SUB,   32'h0, 5'b00001, 0, 0);
    put_row(4,  32'hFFF00293, 1, 5'd4, 0, rv_isa_pkg::IOP_ADDI,  32'hFFFFFFFF, 5'b00001, 0, 0);
    put_row(5,  32'h12345337, 1, 5'd5, 1, rv_isa_pkg::IOP_LUI,   32'h12345000, 5'b00001, 1, 0);
    put_row(6,  32'h12345337, 0, 5'd0, 0, rv_isa_pkg::IOP_LUI,   32'h12345000, 5'b00001, 0, 0);
    put_row(7,  32'h00812383, 1, 5'd6, 0, rv_isa_pkg::IOP_LW,    32'h8, 5'b00101, 0, 0);
    put_row(8,  32'hFE112E23, 1, 5'd7, 0, rv_isa_pkg::IOP_SW,    32'hFFFFFFFC, 5'b00010, 0, 0);
    put_row(9,  32'hFE101CE3, 1, 5'd0, 0, rv_isa_pkg::IOP_BNE,   32'hFFFFFFF8, 5'b10000, 0, 0);
    put_row(10, 32'h0010046F, 0, 5'd0, 0, rv_isa_pkg::IOP_JAL,   32'h800, 5'b01001, 0, 0);
    put_row(11, 32'h00408067, 1, 5'd8, 0, rv_isa_pkg::IOP_JALR,  32'h4, 5'b01000, 0, 0);
    put_row(12, 32'h022084B3, 1, 5'd28, 0, rv_isa_pkg::IOP_INVALID, 32'h0, 5'b00000, 0, 0);
    put_row(13, 32'h01DE0033, 1, 5'd29, 0, rv_isa_pkg::IOP_ADD,  32'h0, 5'b00000, 0, 0);
    put_row(14, 32'h01EE8033, 1, 5'd30, 0, rv_isa_pkg::IOP_ADD,  32'h0, 5'b00000, 0, 0);
    put_row(15, 32'h01B0A023, 0, 5'd0, 0, rv_isa_pkg::IOP_SW,    32'h0, 5'b00010, 0, 0);
    put_row(16, 32'h01B0A023, 0, 5'd0, 0, rv_isa_pkg::IOP_SW,    32'h0, 5'b00010, 0, 1);
    put_row(17, 32'h01F0A223, 0, 5'd0, 0, rv_isa_pkg::IOP_SW,    32'h4, 5'b00010, 0, 0);
    put_row(18, 32'h00000013, 0, 5'd0, 0, rv_isa_pkg::IOP_ADDI,  32'h0, 5'b00000, 0, 0);
  endtask

  // Register read as seen in the cycle of the writeback
  function automatic logic [31:0] read_reg(input logic [4:0] idx);
    if (wb.wr_reg && writable(wb.wregno) && (wb.wregno == idx)) return wb.regval;
    return model_regs[idx];
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // Main table loop
  initial begin : stimulus
    stim_row_t              row;
    de_pipe_pkg::de_latch_t exp;
    logic [31:0]            rnd;
    logic [4:0]             rs2;
    reset      = 1'b1;
    fe         = '0;
    wb         = '0;
    br_mispred = 1'b0;
    op3_sent   = 1'b0;
    rnd        = 32'had417d27;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    fill_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      row = rows[i];
      while (row.wait_fu && !fu_out.csr_in.result_taken) begin
        fe = '0;                                     // Idle until the result is parked
        wb = '0;
        br_mispred = 1'b0;
        @(negedge clk);
      end
      rnd        = xorshift(rnd);
      fe.valid   = 1'b1;
      fe.inst    = row.instr;
      fe.pc      = i * 4;
      wb.wr_reg  = row.wb_en;
      wb.wregno  = row.wb_idx;
      wb.regval  = rnd;
      br_mispred = row.br;
      if (row.wb_en && row.wb_idx == 5'd28) exp_aluop = rnd[3:0];
      if (row.wb_en && row.wb_idx == 5'd29) exp_op1 = rnd;
      if (row.wb_en && row.wb_idx == 5'd30) exp_op2 = rnd;
      #1;
      exp = '0;
      if (!row.stall) begin
        rs2         = row.instr[24:20];
        exp.valid   = 1'b1;
        exp.inst    = row.instr;
        exp.pc      = i * 4;
        exp.op_i    = row.op;
        exp.rs1_val = read_reg(row.instr[19:15]);
        if (rs2 == 5'd31) exp.rs2_val = fu_in.op3;
        else if (rs2 == 5'd27) exp.rs2_val = {29'b0, fu_in.csr_out};
        else exp.rs2_val = read_reg(rs2);
        exp.imm     = row.imm;
        {exp.is_br, exp.is_jmp, exp.rd_mem, exp.wr_mem, exp.wr_reg} = row.flags;
        exp.rd      = row.instr[11:7];
      end
      check_stall(stall, row.stall);
      @(posedge clk);
      if (wb.wr_reg && writable(wb.wregno)) model_regs[wb.wregno] = wb.regval;
      if (!row.stall && (row.op == rv_isa_pkg::IOP_SW) && (row.instr[24:20] == 5'd31)) begin
        op3_sent = 1'b1;                             // OP3 store has left decode
      end
      @(negedge clk);
      check_de_out(de_out, exp);
    end
    fe = '0;
    wb = '0;
    while (!fu_done) @(negedge clk);
    $display("Errors: de_out %0d, csr_in %0d, stall %0d, fu words %0d, total %0d",
             de_errors, csr_errors, stall_errors, word_errors,
             de_errors + csr_errors + stall_errors + word_errors);
    if (de_errors + csr_errors + stall_errors + word_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  ////////////////////
  // FU model, ready bits after random delays
  initial begin : fu_model
    logic [31:0] frnd;
    fu_in   = '0;
    fu_done = 1'b0;
    frnd    = xorshift(32'had417d27 ^ 32'h5a5a5a5a);
    wait (!reset);
    @(negedge clk);
    frnd = xorshift(frnd);
    repeat (1 + frnd % MAX_FU_DELAY) begin
      @(negedge clk);
      check_csr_in(fu_out.csr_in, 3'b000);          // No strobe before ready
    end
    fu_in.csr_out.op1_ready = 1'b1;
    @(negedge clk);
    while (!fu_out.csr_in.op1_stable) begin
      check_csr_in(fu_out.csr_in, 3'b000);
      @(negedge clk);
    end
    check_csr_in(fu_out.csr_in, 3'b010);
    check_word("fu_out.op1", fu_out.op1, exp_op1);
    check_word("fu_out.aluop", {28'b0, fu_out.aluop}, {28'b0, exp_aluop});
    fu_in.csr_out.op1_ready = 1'b0;
    frnd = xorshift(frnd);
    repeat (1 + frnd % MAX_FU_DELAY) begin
      @(negedge clk);
      check_csr_in(fu_out.csr_in, 3'b000);
    end
    fu_in.csr_out.op2_ready = 1'b1;
    @(negedge clk);
    while (!fu_out.csr_in.op2_stable) begin
      check_csr_in(fu_out.csr_in, 3'b000);
      @(negedge clk);
    end
    check_csr_in(fu_out.csr_in, 3'b100);
    check_word("fu_out.op2", fu_out.op2, exp_op2);
    fu_in.csr_out.op2_ready = 1'b0;
    frnd = xorshift(frnd);
    repeat (1 + frnd % MAX_FU_DELAY) begin
      @(negedge clk);
      check_csr_in(fu_out.csr_in, 3'b000);
    end
    frnd = xorshift(frnd);
    fu_in.op3 = frnd;
    fu_in.csr_out.result_valid = 1'b1;
    @(negedge clk);
    while (!fu_out.csr_in.result_taken) begin
      check_csr_in(fu_out.csr_in, 3'b000);
      @(negedge clk);
    end
    fu_in.csr_out.result_valid = 1'b0;
    // Held through every instruction up to the OP3 store
    while (!op3_sent) begin
      check_csr_in(fu_out.csr_in, 3'b001);
      @(negedge clk);
    end
    check_csr_in(fu_out.csr_in, 3'b000);            // Released right after that store
    fu_done = 1'b1;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verification
design/rv_isa_pkg.sv
design/de_pipe_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/scoreboard.sv
design/alu_operand_regs.sv
design/alu_handshake_fsm.sv
design/de_issue_latch.sv
design/de_stage_top.sv
verification/tb_de_stage.sv
